/* column_buffer.sv */
`timescale 1ns/1ps

module column_buffer #(
   parameter int NUM_DRIVERS = 4
) (
   input  logic                  clk,
   input  logic                  nrst,
   // Write side, from the decoder
   input  logic                  wr_en,
   input  logic [(NUM_DRIVERS > 1 ? $clog2(NUM_DRIVERS) : 1)-1:0] wr_addr,
   input  led_pkg::led_word_u    wr_data,
   input  logic                  commit,
   output logic                  back_full,
   // Read side, to the sequencer
   output logic                  col_valid,
   input  logic                  col_ready,
   output led_pkg::led_word_u    col_data [NUM_DRIVERS]
);

   led_pkg::led_word_u back_bank [NUM_DRIVERS];

   // Committed column is offered as-is
   assign col_valid = back_full;

   always_ff @(posedge clk or negedge nrst) begin
      if (!nrst) begin
         back_full <= 1'b0;
         for (int i = 0; i < NUM_DRIVERS; i++) begin
            back_bank[i] <= '0;
            col_data[i]  <= '0;
         end
      end else begin
         // Host fills the back bank
         if (wr_en && wr_addr < NUM_DRIVERS) begin
            back_bank[wr_addr] <= wr_data;
         end
         // Sequencer takes it: swap into the front
         if (col_ready) begin
            col_data <= back_bank;
         end
         // Commit and take never overlap, decoder stalls the commit
         back_full <= (back_full & ~col_ready) | commit;
      end
   end

endmodule

/* files.f */
led_pkg.sv
host_cmd_decoder.sv
column_buffer.sv
tlc_sequencer.sv
led_panel_top.sv
tb_led_panel_assertions.sv
tb_led_panel.sv

/* host_cmd_decoder.sv */
`timescale 1ns/1ps

module host_cmd_decoder #(
   parameter int NUM_DRIVERS = 4
) (
   input  logic                  clk,
   input  logic                  nrst,
   // Host command port
   input  logic                  cmd_valid,
   input  led_pkg::cmd_op_e      cmd_op,
   input  logic [(NUM_DRIVERS > 1 ? $clog2(NUM_DRIVERS) : 1)-1:0] cmd_addr,
   input  led_pkg::led_word_u    cmd_data,
   output logic                  cmd_ready,
   // Column buffer side
   input  logic                  back_full,
   output logic                  wr_en,
   output logic [(NUM_DRIVERS > 1 ? $clog2(NUM_DRIVERS) : 1)-1:0] wr_addr,
   output led_pkg::led_word_u    wr_data,
   output logic                  commit,
   // Configuration handshake to sequencer
   input  logic                  conf_ready,
   output logic                  conf_valid,
   output led_pkg::led_word_u    conf_word
);

   localparam int AW = NUM_DRIVERS > 1 ? $clog2(NUM_DRIVERS) : 1;

   logic take;

   // Back-pressure per opcode
   always_comb begin
      case (cmd_op)
         // Only one configuration in flight
         led_pkg::OP_CONF:   cmd_ready = ~conf_valid;
         // Commit in the pipe counts as full too
         led_pkg::OP_COMMIT: cmd_ready = ~(back_full | commit);
         default:            cmd_ready = 1'b1;
      endcase
   end

   assign take = cmd_valid & cmd_ready;

   // Control strobes and the config register
   always_ff @(posedge clk or negedge nrst) begin
      if (!nrst) begin
         wr_en      <= 1'b0;
         commit     <= 1'b0;
         // Default config goes out right after reset
         conf_valid <= 1'b1;
         conf_word  <= led_pkg::FC_DEFAULT;
      end else begin
         wr_en  <= take & (cmd_op == led_pkg::OP_PIXEL);
         commit <= take & (cmd_op == led_pkg::OP_COMMIT);
         if (take && cmd_op == led_pkg::OP_CONF) begin
            conf_valid <= 1'b1;
            conf_word  <= cmd_data;
         end else if (conf_ready) begin
            // Sequencer has its own copy now
            conf_valid <= 1'b0;
         end
      end
   end

   // Pixel payload, qualified by wr_en
   always_ff @(posedge clk) begin
      if (take && cmd_op == led_pkg::OP_PIXEL) begin
         wr_addr <= AW'(cmd_addr);
         wr_data <= cmd_data;
      end
   end

endmodule

/* led_panel_top.sv */
`timescale 1ns/1ps

module led_panel_top #(
   parameter int NUM_DRIVERS = 4
) (
   input  logic                  clk,
   input  logic                  nrst,
   // Host port
   input  logic                  cmd_valid,
   input  led_pkg::cmd_op_e      cmd_op,
   input  logic [(NUM_DRIVERS > 1 ? $clog2(NUM_DRIVERS) : 1)-1:0] cmd_addr,
   input  led_pkg::led_word_u    cmd_data,
   output logic                  cmd_ready,
   // Driver pins
   output logic                  driver_sclk,
   output logic                  driver_gclk,
   output logic                  driver_lat,
   output logic [NUM_DRIVERS-1:0] drivers_sin
);

   localparam int AW = NUM_DRIVERS > 1 ? $clog2(NUM_DRIVERS) : 1;

   // Decoder to buffer
   logic               wr_en;
   logic [AW-1:0]      wr_addr;
   led_pkg::led_word_u wr_data;
   logic               commit;
   logic               back_full;
   // Config handshake
   logic               conf_valid;
   logic               conf_ready;
   led_pkg::led_word_u conf_word;
   // Column handshake
   logic               col_valid;
   logic               col_ready;
   led_pkg::led_word_u col_data [NUM_DRIVERS];

   host_cmd_decoder #(.NUM_DRIVERS(NUM_DRIVERS)) i_decoder (
      .clk, .nrst, .cmd_valid, .cmd_op, .cmd_addr, .cmd_data, .cmd_ready,
      .back_full, .wr_en, .wr_addr, .wr_data, .commit,
      .conf_ready, .conf_valid, .conf_word
   );

   column_buffer #(.NUM_DRIVERS(NUM_DRIVERS)) i_buffer (
      .clk, .nrst, .wr_en, .wr_addr, .wr_data, .commit, .back_full,
      .col_valid, .col_ready, .col_data
   );

   tlc_sequencer #(.NUM_DRIVERS(NUM_DRIVERS)) i_sequencer (
      .clk, .nrst, .conf_valid, .conf_word, .conf_ready,
      .col_valid, .col_data, .col_ready,
      .driver_sclk, .driver_gclk, .driver_lat, .drivers_sin
   );

endmodule

/* led_pkg.sv */
package led_pkg;

   // Driver word geometry
   localparam int WORD_BITS = 48;
   localparam int LED_COUNT = 16;

   // Protocol lengths, in SCLK strobes
   localparam int PREP_CYCLES = 15;
   localparam int WRTFC_BITS  = 5;
   localparam int LATGS_BITS  = 3;
   // Idle time after a WRTFC before the next command
   localparam int GAP_CYCLES  = 5;

   // Host opcodes
   typedef enum logic [1:0] {
      OP_NOP    = 2'b00,
      OP_CONF   = 2'b01,
      OP_PIXEL  = 2'b10,
      OP_COMMIT = 2'b11
   } cmd_op_e;

   typedef struct packed {
      logic r;
      logic g;
      logic b;
   } led_rgb_t;

   // One driver word, either FC register bits or sixteen RGB LEDs
   typedef union packed {
      logic [WORD_BITS-1:0]           fc;
      led_rgb_t [LED_COUNT-1:0]       leds;
   } led_word_u;

   // Board routing: entry k is the LED shifted in slots 3k..3k+2
   localparam logic [0:LED_COUNT-1][3:0] LED_ORDER = '{
      4'd6, 4'd7, 4'd9, 4'd8, 4'd10, 4'd11, 4'd13, 4'd12,
      4'd14, 4'd15, 4'd1, 4'd0, 4'd2, 4'd3, 4'd5, 4'd4
   };

   // Power-up function control word
   localparam logic [WORD_BITS-1:0] FC_DEFAULT = 48'h4000_8c3f_ff00;

endpackage

/* run.sh */
#!/usr/bin/env bash
# Build and run the LED panel testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
   --top-module tb_led_panel -f files.f -o sim_led_panel
status=$?
if [ "$status" -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit "$status"
fi

./obj_dir/sim_led_panel
status=$?
if [ "$status" -ne 0 ]; then
   echo "Simulation failed with status $status"
   exit "$status"
fi

echo "Simulation finished cleanly"
exit 0

/* tb_led_panel.sv */
`timescale 1ns/1ps

module tb_led_panel;

   localparam int NUM_DRIVERS = 4;
   localparam int AW = NUM_DRIVERS > 1 ? $clog2(NUM_DRIVERS) : 1;
   localparam int WB = led_pkg::WORD_BITS;
   localparam int CONF_LEN = led_pkg::PREP_CYCLES + led_pkg::WORD_BITS;
   localparam int TIMEOUT = 200;

   logic                   clk;
   logic                   nrst;
   logic                   cmd_valid;
   led_pkg::cmd_op_e       cmd_op;
   logic [AW-1:0]          cmd_addr;
   led_pkg::led_word_u     cmd_data;
   logic                   cmd_ready;
   logic                   driver_sclk;
   logic                   driver_gclk;
   logic                   driver_lat;
   logic [NUM_DRIVERS-1:0] drivers_sin;

   // One entry per sclk strobe of the last burst
   logic [NUM_DRIVERS-1:0] sin_cap [64];
   logic                   lat_cap [64];
   logic                   gclk_cap [64];
   // gclk on the first idle cycle after the burst
   logic                   gclk_after;
   int                     n_cap;
   logic [31:0]            seed;
   led_pkg::led_word_u     col_a [NUM_DRIVERS];
   led_pkg::led_word_u     col_b [NUM_DRIVERS];
   led_pkg::led_word_u     conf_w;

   led_panel_top #(.NUM_DRIVERS(NUM_DRIVERS)) i_dut (
      .clk, .nrst, .cmd_valid, .cmd_op, .cmd_addr, .cmd_data, .cmd_ready,
      .driver_sclk, .driver_gclk, .driver_lat, .drivers_sin
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s ^ (s << 13);
      x = x ^ (x >> 17);
      return x ^ (x << 5);
   endfunction

   task automatic rand_word(output led_pkg::led_word_u w);
      logic [15:0] hi;
      seed = xorshift(seed);
      hi = seed[15:0];
      seed = xorshift(seed);
      w.fc = {hi, seed};
   endtask

   // Serial bit k of a driver word, per the board LED routing
   function automatic logic model_bit(input led_pkg::led_word_u w, input int k);
      led_pkg::led_rgb_t p;
      p = w.leds[led_pkg::LED_ORDER[k / 3]];
      case (k % 3)
         0: return p.r;
         1: return p.g;
         default: return p.b;
      endcase
   endfunction

   task automatic stop_run(input string msg);
      $display("%s", msg);
      $display("Test FAILED");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_word(input string name, input led_pkg::led_word_u exp,
                             input led_pkg::led_word_u got);
      if (got !== exp)
         stop_run($sformatf("ERR %s: expected %012h, got %012h", name, exp.fc, got.fc));
   endtask

   task automatic check_flag(input string name, input logic exp, input logic got);
      if (got !== exp)
         stop_run($sformatf("ERR %s: expected %b, got %b", name, exp, got));
   endtask

   task automatic check_count(input string name, input int exp, input int got);
      if (got != exp)
         stop_run($sformatf("ERR %s: expected %0d, got %0d", name, exp, got));
   endtask

   // Host transfer, stalls counts cycles with cmd_ready low
   task automatic send_cmd(input led_pkg::cmd_op_e op, input logic [AW-1:0] addr,
                           input led_pkg::led_word_u data, output int stalls);
      stalls = 0;
      @(negedge clk);
      cmd_valid = 1'b1;
      cmd_op    = op;
      cmd_addr  = addr;
      cmd_data  = data;
      #5;
      while (!cmd_ready) begin
         stalls++;
         if (stalls > TIMEOUT) stop_run("cmd_ready stayed low too long");
         @(negedge clk);
         #5;
      end
      // Transfer on the next rising edge
      @(negedge clk);
      cmd_valid = 1'b0;
      cmd_op    = led_pkg::OP_NOP;
   endtask

   task automatic fill_column(input led_pkg::led_word_u words [NUM_DRIVERS],
                              output int commit_stalls);
      int s;
      for (int d = 0; d < NUM_DRIVERS; d++) send_cmd(led_pkg::OP_PIXEL, AW'(d), words[d], s);
      send_cmd(led_pkg::OP_COMMIT, '0, '0, commit_stalls);
   endtask

   // Quarter period before the rising edge, lat already settled
   task automatic sample_pins();
      @(negedge clk);
      #5;
   endtask

   task automatic capture_burst(input string name);
      int waited;
      waited = 0;
      n_cap = 0;
      sample_pins();
      while (!driver_sclk) begin
         waited++;
         if (waited > TIMEOUT) stop_run({name, ": no sclk burst started in time"});
         sample_pins();
      end
      while (driver_sclk) begin
         if (n_cap == 64) stop_run({name, ": sclk burst did not end"});
         sin_cap[n_cap]  = drivers_sin;
         lat_cap[n_cap]  = driver_lat;
         gclk_cap[n_cap] = driver_gclk;
         n_cap++;
         sample_pins();
      end
      gclk_after = driver_gclk;
   endtask

   // PREP strobes, then the FC word MSB first with WRTFC on the tail
   task automatic expect_config_burst(input string name, input led_pkg::led_word_u w);
      led_pkg::led_word_u got;
      capture_burst(name);
      check_count({name, " length"}, CONF_LEN, n_cap);
      for (int d = 0; d < NUM_DRIVERS; d++) begin
         for (int k = 0; k < WB; k++) got.fc[WB-1-k] = sin_cap[led_pkg::PREP_CYCLES + k][d];
         check_word({name, " word"}, w, got);
      end
      for (int k = 0; k < CONF_LEN; k++) begin
         if (k < led_pkg::PREP_CYCLES) check_flag({name, " prep sin"}, 1'b0, |sin_cap[k]);
         check_flag({name, " lat"},
                    k < led_pkg::PREP_CYCLES || k >= CONF_LEN - led_pkg::WRTFC_BITS, lat_cap[k]);
         check_flag({name, " gclk"}, 1'b0, gclk_cap[k]);
      end
      check_flag({name, " gclk after"}, 1'b0, gclk_after);
   endtask

   task automatic expect_column_burst(input string name,
                                      input led_pkg::led_word_u words [NUM_DRIVERS],
                                      input logic gclk_during);
      led_pkg::led_word_u exp;
      led_pkg::led_word_u got;
      capture_burst(name);
      check_count({name, " length"}, WB, n_cap);
      for (int d = 0; d < NUM_DRIVERS; d++) begin
         for (int k = 0; k < WB; k++) begin
            exp.fc[WB-1-k] = model_bit(words[d], k);
            got.fc[WB-1-k] = sin_cap[k][d];
         end
         check_word($sformatf("%s driver %0d", name, d), exp, got);
      end
      for (int k = 0; k < WB; k++) begin
         check_flag({name, " lat"}, k >= WB - led_pkg::LATGS_BITS, lat_cap[k]);
         check_flag({name, " gclk"}, gclk_during, gclk_cap[k]);
      end
      // Bank latched, display starts
      check_flag({name, " gclk after"}, 1'b1, gclk_after);
   endtask

   task automatic column_stream_test();
      int s;
      for (int d = 0; d < NUM_DRIVERS; d++) rand_word(col_a[d]);
      fill_column(col_a, s);
      expect_column_burst("column_stream", col_a, 1'b0);
   endtask

   task automatic reconfig_test();
      int s;
      rand_word(conf_w);
      send_cmd(led_pkg::OP_CONF, '0, conf_w, s);
      expect_config_burst("reconfig", conf_w);
      for (int d = 0; d < NUM_DRIVERS; d++) rand_word(col_a[d]);
      fill_column(col_a, s);
      // Still dark until this column is latched
      expect_column_burst("reconfig column", col_a, 1'b0);
   endtask

   task automatic double_buffer_test();
      int s;
      int again_stalls;
      for (int d = 0; d < NUM_DRIVERS; d++) begin
         rand_word(col_a[d]);
         rand_word(col_b[d]);
      end
      fork
         begin
            fill_column(col_a, s);
            // Second column fills the back bank while the first shifts
            fill_column(col_b, s);
            send_cmd(led_pkg::OP_COMMIT, '0, '0, again_stalls);
            check_flag("double_buffer commit stall", 1'b1, again_stalls > 0);
         end
         begin
            expect_column_burst("double_buffer first", col_a, 1'b1);
            expect_column_burst("double_buffer second", col_b, 1'b1);
            expect_column_burst("double_buffer repeat", col_b, 1'b1);
         end
      join
   endtask

   task automatic priority_test();
      int s;
      rand_word(conf_w);
      for (int d = 0; d < NUM_DRIVERS; d++) begin
         rand_word(col_a[d]);
         rand_word(col_b[d]);
      end
      fork
         begin
            fill_column(col_a, s);
            // Config and next column both wait for the shift to end
            send_cmd(led_pkg::OP_CONF, '0, conf_w, s);
            fill_column(col_b, s);
         end
         begin
            expect_column_burst("priority busy column", col_a, 1'b1);
            expect_config_burst("priority config", conf_w);
            expect_column_burst("priority pending column", col_b, 1'b0);
         end
      join
   endtask

   initial begin
      nrst      = 1'b0;
      cmd_valid = 1'b0;
      cmd_op    = led_pkg::OP_NOP;
      cmd_addr  = '0;
      cmd_data  = '0;
      seed      = 32'h22e8;
      repeat (4) @(negedge clk);
      nrst = 1'b1;
      // Default FC word goes out right after reset
      expect_config_burst("boot_config", led_pkg::FC_DEFAULT);
      column_stream_test();
      reconfig_test();
      double_buffer_test();
      priority_test();
      $display("Test OK");
      $finish;
   end

endmodule

/* tb_led_panel_assertions.sv */
`timescale 1ns/1ps

module tb_led_panel_assertions #(
   parameter int NUM_DRIVERS = 4
) (
   input logic               clk,
   input logic               nrst,
   input logic               cmd_valid,
   input logic               cmd_ready,
   input led_pkg::cmd_op_e   cmd_op,
   input logic [(NUM_DRIVERS > 1 ? $clog2(NUM_DRIVERS) : 1)-1:0] cmd_addr,
   input led_pkg::led_word_u cmd_data,
   input logic               driver_sclk,
   input logic               driver_gclk,
   input logic               driver_lat,
   input logic               conf_ready,
   input logic               col_ready
);

   // Config in progress, from its acceptance to the next column
   logic in_conf;

   always_ff @(posedge clk or negedge nrst) begin
      if (!nrst) begin
         in_conf <= 1'b0;
      end else if (conf_ready) begin
         in_conf <= 1'b1;
      end else if (col_ready) begin
         in_conf <= 1'b0;
      end
   end

   // Latch only together with a shift strobe
   lat_needs_sclk: assert property (@(posedge clk) disable iff (!nrst)
      driver_lat |-> driver_sclk)
      else $error("lat high while sclk low");

   // Drivers must not display while FC is written
   no_gclk_in_conf: assert property (@(posedge clk) disable iff (!nrst)
      in_conf && driver_lat |-> !driver_gclk)
      else $error("gclk high during a configuration latch");

   host_holds_cmd: assert property (@(posedge clk) disable iff (!nrst)
      cmd_valid && !cmd_ready |=>
         cmd_valid && $stable(cmd_op) && $stable(cmd_addr) && $stable(cmd_data))
      else $error("host command changed while stalled");

endmodule

bind led_panel_top tb_led_panel_assertions #(.NUM_DRIVERS(NUM_DRIVERS)) i_assertions (
   .clk, .nrst, .cmd_valid, .cmd_ready, .cmd_op, .cmd_addr, .cmd_data,
   .driver_sclk, .driver_gclk, .driver_lat, .conf_ready, .col_ready
);

/* tlc_sequencer.sv */
`timescale 1ns/1ps

module tlc_sequencer #(
   parameter int NUM_DRIVERS = 4
) (
   input  logic                  clk,
   input  logic                  nrst,
   // Configuration handshake
   input  logic                  conf_valid,
   input  led_pkg::led_word_u    conf_word,
   output logic                  conf_ready,
   // Column handshake
   input  logic                  col_valid,
   input  led_pkg::led_word_u    col_data [NUM_DRIVERS],
   output logic                  col_ready,
   // Driver pins
   output logic                  driver_sclk,
   output logic                  driver_gclk,
   output logic                  driver_lat,
   output logic [NUM_DRIVERS-1:0] drivers_sin
);

   // FSM encoding
   localparam logic [2:0] IDLE   = 3'd0;
   localparam logic [2:0] PREP   = 3'd1;
   localparam logic [2:0] CONFIG = 3'd2;
   localparam logic [2:0] GAP    = 3'd3;
   localparam logic [2:0] SHIFT  = 3'd4;
   localparam logic [2:0] PAUSE  = 3'd5;

   // Counter end values
   localparam logic [5:0] LAST_PREP = 6'(led_pkg::PREP_CYCLES - 1);
   localparam logic [5:0] LAST_BIT  = 6'(led_pkg::WORD_BITS - 1);
   localparam logic [5:0] LAST_GAP  = 6'(led_pkg::GAP_CYCLES - 1);
   // First cycle with lat high
   localparam logic [5:0] WRTFC_START = 6'(led_pkg::WORD_BITS - led_pkg::WRTFC_BITS);
   localparam logic [5:0] LATGS_START = 6'(led_pkg::WORD_BITS - led_pkg::LATGS_BITS);

   logic [2:0]         state;
   logic [5:0]         cnt;
   // LED slot and colour inside a SHIFT
   logic [3:0]         slot;
   logic [1:0]         rgb_idx;
   led_pkg::led_word_u conf_sr;
   // A GS bank is latched since the last config
   logic               gs_loaded;
   logic [5:0]         fc_idx;

   // Accept in IDLE, config first
   assign conf_ready = (state == IDLE) & conf_valid;
   assign col_ready  = (state == IDLE) & ~conf_valid & col_valid;

   always_ff @(posedge clk or negedge nrst) begin
      if (!nrst) begin
         state     <= IDLE;
         cnt       <= '0;
         slot      <= '0;
         rgb_idx   <= '0;
         gs_loaded <= 1'b0;
      end else begin
         cnt <= cnt + 6'd1;
         case (state)
            IDLE: begin
               cnt     <= '0;
               slot    <= '0;
               rgb_idx <= '0;
               if (conf_valid) begin
                  state     <= PREP;
                  // Drivers leave GS display during config
                  gs_loaded <= 1'b0;
               end else if (col_valid) begin
                  state <= SHIFT;
               end
            end
            // FCWRTEN strobes
            PREP: begin
               if (cnt == LAST_PREP) begin
                  state <= CONFIG;
                  cnt   <= '0;
               end
            end
            CONFIG: begin
               if (cnt == LAST_BIT) begin
                  state <= GAP;
                  cnt   <= '0;
               end
            end
            GAP: begin
               if (cnt == LAST_GAP) begin
                  state <= IDLE;
               end
            end
            SHIFT: begin
               rgb_idx <= (rgb_idx == 2'd2) ? 2'd0 : rgb_idx + 2'd1;
               if (rgb_idx == 2'd2) begin
                  slot <= slot + 4'd1;
               end
               if (cnt == LAST_BIT) begin
                  // LATGS done, bank is valid
                  state     <= PAUSE;
                  gs_loaded <= 1'b1;
               end
            end
            PAUSE: state <= IDLE;
            default: state <= IDLE;
         endcase
      end
   end

   // Config word copy, frees the decoder for the next one
   always_ff @(posedge clk) begin
      if (conf_ready) begin
         conf_sr <= conf_word;
      end
   end

   assign driver_sclk = (state == PREP) | (state == CONFIG) | (state == SHIFT);
   assign driver_gclk = gs_loaded & ((state == IDLE) | (state == SHIFT) | (state == PAUSE));

   // lat on the falling edge so it is stable around the SCLK rise
   always_ff @(negedge clk or negedge nrst) begin
      if (!nrst) begin
         driver_lat <= 1'b0;
      end else begin
         case (state)
            PREP:    driver_lat <= 1'b1;
            CONFIG:  driver_lat <= cnt >= WRTFC_START;
            SHIFT:   driver_lat <= cnt >= LATGS_START;
            default: driver_lat <= 1'b0;
         endcase
      end
   end

   // MSB first for the FC word
   assign fc_idx = LAST_BIT - cnt;

   always_comb begin
      led_pkg::led_rgb_t pix;
      for (int d = 0; d < NUM_DRIVERS; d++) begin
         pix = col_data[d].leds[led_pkg::LED_ORDER[slot]];
         case (state)
            // Same config on every driver
            CONFIG: drivers_sin[d] = conf_sr.fc[fc_idx];
            SHIFT: begin
               case (rgb_idx)
                  2'd0:    drivers_sin[d] = pix.r;
                  2'd1:    drivers_sin[d] = pix.g;
                  default: drivers_sin[d] = pix.b;
               endcase
            end
            default: drivers_sin[d] = 1'b0;
         endcase
      end
   end

endmodule
